//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0 --Mdir obj_dir
TOP      = idStageTb
FILELIST = filelist.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/idStageTb.sv
`timescale 1ns/1ps

module idStageTb;
    import idPkg::*;

    logic     clk;
    logic     arstN;
    addr_t    pc;
    inst_t    inst;
    data_t    reg1Data;
    data_t    reg2Data;
    logic     exFwdE;
    regIdx_t  exFwdIdx;
    data_t    exFwdData;
    logic     memFwdE;
    regIdx_t  memFwdIdx;
    data_t    memFwdData;
    logic     reg1E;
    logic     reg2E;
    regIdx_t  reg1Idx;
    regIdx_t  reg2Idx;
    logic     idStall;
    addr_t    idExPc;
    logic     idExRdE;
    regIdx_t  idExRdIdx;
    instIdx_t idExInstIdx;
    logic     idExValid;
    data_t    idExRs1Data;
    data_t    idExRs2Data;
    data_t    idExImm;

    data_t      tExData;
    data_t      tMemData;
    logic       expR1E;
    logic       expR2E;
    logic       expStall;
    logic [5:0] expIdx;
    logic       expValid;
    logic       expRdE;
    regIdx_t    expRdIdx;
    data_t      expRs1;
    data_t      expRs2;
    data_t      expImm;
    string      lines[$];
    int         lineCount;
    logic       traceLoaded;

    idStage u_idStage (.*);

    always #4 clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abortRun($sformatf("error at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic checkData(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            abortRun($sformatf("error at %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkRegIdx(input regIdx_t got, input regIdx_t exp, input string what);
        if (got !== exp) begin
            abortRun($sformatf("error at %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic checkInstIdx(input instIdx_t got, input instIdx_t exp, input string what);
        if (got !== exp) begin
            abortRun($sformatf("error at %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic loadTrace();
        int    fd;
        string line;
        fd = $fopen("bench/idTrace.txt", "r");
        if (fd == 0) begin
            abortRun("could not open the trace file bench/idTrace.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic applyLine(input string line);
        int n;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            inst, pc, reg1Data, reg2Data, exFwdE, exFwdIdx, tExData, memFwdE, memFwdIdx,
            tMemData, expR1E, expR2E, expStall, expIdx, expValid, expRdE, expRdIdx,
            expRs1, expRs2, expImm);
        if (n != 20) begin
            abortRun($sformatf("trace line has %0d fields instead of 20: %s", n, line));
        end else begin
            exFwdData  = exFwdE ? tExData : $urandom; // Disabled forward data is don't care
            memFwdData = memFwdE ? tMemData : $urandom;
        end
    endtask

    task automatic checkComb();
        checkBit(reg1E, expR1E, "reg1E");
        checkBit(reg2E, expR2E, "reg2E");
        checkRegIdx(reg1Idx, expR1E ? inst[19:15] : 5'd0, "reg1Idx");
        checkRegIdx(reg2Idx, expR2E ? inst[24:20] : 5'd0, "reg2Idx");
        checkBit(idStall, expStall, "idStall");
    endtask

    task automatic checkRegistered();
        checkInstIdx(idExInstIdx, instIdx_t'(expIdx), "idExInstIdx");
        checkBit(idExValid, expValid, "idExValid");
        checkBit(idExRdE, expRdE, "idExRdE");
        checkRegIdx(idExRdIdx, expRdIdx, "idExRdIdx");
        checkData(idExRs1Data, expRs1, "idExRs1Data");
        checkData(idExRs2Data, expRs2, "idExRs2Data");
        checkData(idExImm, expImm, "idExImm");
        checkData(idExPc, expStall ? '0 : pc, "idExPc"); // Bubble clears pc
    endtask

    initial begin
        void'($urandom(32'h898c));
        clk         = 1'b0;
        arstN       = 1'b0;
        pc          = '0;
        inst        = 32'h0000a083; // LW x1 reading its own destination
        reg1Data    = '0;
        reg2Data    = '0;
        exFwdE      = 1'b0;
        exFwdIdx    = '0;
        exFwdData   = '0;
        memFwdE     = 1'b0;
        memFwdIdx   = '0;
        memFwdData  = '0;
        traceLoaded = 1'b0;
        loadTrace();
        lineCount   = lines.size();
        traceLoaded = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        arstN = 1'b1;
        checkBit(idExValid, 1'b0, "idExValid after reset");
        checkBit(idExRdE, 1'b0, "idExRdE after reset");
        checkInstIdx(idExInstIdx, idNop, "idExInstIdx after reset");
        checkBit(idStall, 1'b0, "idStall after reset");
        foreach (lines[i]) begin
            applyLine(lines[i]);
            #6; // Settled just before the next edge
            checkComb();
            @(posedge clk);
            #1;
            checkRegistered();
        end
        $display("test passed");
        $finish;
    end

    initial begin
        wait (traceLoaded);
        #(lineCount * 8 + 200);
        abortRun($sformatf("the trace did not complete within %0d ns", lineCount * 8 + 200));
    end

endmodule : idStageTb

//--- bench/idTrace.txt
# inst pc reg1Data reg2Data exE exIdx exData memE memIdx memData | reg1E reg2E stall
# | instIdx valid rdE rdIdx rs1 rs2 imm (registered, checked one cycle later), all hex
123451b7 100 0 0 0 0 0 0 0 0 0 0 0 01 1 1 03 0 0 12345000
fffff217 104 0 0 0 0 0 0 0 0 0 0 0 02 1 1 04 0 0 fffff000
ff9ff0ef 108 0 0 0 0 0 0 0 0 0 0 0 03 1 1 01 0 0 fffffff8
ffc08167 10c 100 0 0 0 0 0 0 0 1 0 0 04 1 1 02 100 0 fffffffc
fe2088e3 110 11 22 1 1 aaaa 1 1 bbbb 1 1 0 05 1 0 00 aaaa 22 fffffff0
00419463 114 33 44 1 7 eeee 1 4 cccc 1 1 0 06 1 0 00 33 cccc 00000008
fff30403 118 66 0 0 0 0 0 0 0 1 0 0 0b 1 1 08 66 0 ffffffff
00405483 11c 5 0 1 0 dddd 1 0 9999 1 0 0 0f 1 1 09 5 0 4
fea12623 120 2000 a0 0 0 0 0 0 0 1 1 0 12 1 0 00 2000 a0 ffffffec
80060593 124 12 0 0 0 0 0 0 0 1 0 0 13 1 1 0b 12 0 fffff800
41f75693 128 14 0 0 0 0 0 0 0 1 0 0 1b 1 1 0d 14 0 1f
00309793 12c 1 99 0 0 0 0 0 0 1 0 0 19 1 1 0f 1 0 3
41288833 130 17 18 0 0 0 0 0 0 1 1 0 1d 1 1 10 17 18 0
015a79b3 134 20 21 1 15 7777 0 0 0 1 1 0 25 1 1 13 20 7777 0
ffffffff 138 1 2 0 0 0 0 0 0 0 0 0 00 0 0 00 0 0 0
00112063 13c 1 2 0 0 0 0 0 0 0 0 0 00 0 0 00 0 0 0
0000a283 140 40 0 0 0 0 0 0 0 1 0 0 0d 1 1 05 40 0 0
00728333 144 0 77 0 0 0 0 0 0 1 1 1 00 0 0 00 0 0 0
00728333 144 0 77 0 0 0 1 5 1234 1 1 0 1c 1 1 06 1234 77 0
00000013 148 3 0 0 0 0 0 0 0 1 0 0 13 1 1 00 3 0 0

//--- filelist.f
hw/idPkg.sv
hw/instDecoder.sv
hw/immGen.sv
hw/operandSelect.sv
hw/idExReg.sv
hw/idStage.sv
bench/idStageTb.sv

//--- hw/idExReg.sv
`timescale 1ns/1ps

module idExReg (
    input  logic             clk,
    input  logic             arstN,
    input  logic             stall,
    input  idPkg::addr_t     pc,
    input  logic             rdE,
    input  idPkg::regIdx_t   rdIdx,
    input  idPkg::instIdx_t  instIdx,
    input  logic             instValid,
    input  idPkg::data_t     rs1Data,
    input  idPkg::data_t     rs2Data,
    input  idPkg::data_t     imm,
    output idPkg::addr_t     exPc,
    output logic             exRdE,
    output idPkg::regIdx_t   exRdIdx,
    output idPkg::instIdx_t  exInstIdx,
    output logic             exValid,
    output idPkg::data_t     exRs1Data,
    output idPkg::data_t     exRs2Data,
    output idPkg::data_t     exImm
);
    import idPkg::*;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exPc      <= '0;
            exRdE     <= 1'b0;
            exRdIdx   <= '0;
            exInstIdx <= idNop;
            exValid   <= 1'b0;
            exRs1Data <= '0;
            exRs2Data <= '0;
            exImm     <= '0;
        end else if (stall) begin
            exPc      <= '0; // Bubble while the held instruction waits
            exRdE     <= 1'b0;
            exRdIdx   <= '0;
            exInstIdx <= idNop;
            exValid   <= 1'b0;
            exRs1Data <= '0;
            exRs2Data <= '0;
            exImm     <= '0;
        end else begin
            exPc      <= pc;
            exRdE     <= rdE;
            exRdIdx   <= rdIdx;
            exInstIdx <= instIdx;
            exValid   <= instValid;
            exRs1Data <= rs1Data;
            exRs2Data <= rs2Data;
            exImm     <= imm;
        end
    end

endmodule : idExReg

//--- hw/idPkg.sv
package idPkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] data_t;
    typedef logic [xlen-1:0] addr_t;
    typedef logic [4:0]      regIdx_t;
    typedef logic [31:0]     inst_t;

    // NOP stays at zero so a cleared register reads as a bubble
    typedef enum logic [5:0] {
        idNop = 6'd0,
        idLui, idAuipc, idJal, idJalr,
        idBeq, idBne, idBlt, idBge, idBltu, idBgeu,
        idLb, idLh, idLw, idLbu, idLhu,
        idSb, idSh, idSw,
        idAddi, idSlti, idSltiu, idXori, idOri, idAndi,
        idSlli, idSrli, idSrai,
        idAdd, idSub, idSll, idSlt, idSltu,
        idXor, idSrl, idSra, idOr, idAnd
    } instIdx_t;

    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opRegImm = 7'b0010011;
    localparam logic [6:0] opRegReg = 7'b0110011;

    // ALU funct3 shared by the register-immediate and register-register groups
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    function automatic logic isLoad(instIdx_t idx);
        return idx inside {idLb, idLh, idLw, idLbu, idLhu};
    endfunction

endpackage : idPkg

//--- hw/idStage.sv
`timescale 1ns/1ps

module idStage (
    input  logic             clk,
    input  logic             arstN,
    input  idPkg::addr_t     pc,
    input  idPkg::inst_t     inst,
    input  idPkg::data_t     reg1Data,
    input  idPkg::data_t     reg2Data,
    input  logic             exFwdE,
    input  idPkg::regIdx_t   exFwdIdx,
    input  idPkg::data_t     exFwdData,
    input  logic             memFwdE,
    input  idPkg::regIdx_t   memFwdIdx,
    input  idPkg::data_t     memFwdData,
    output logic             reg1E,
    output logic             reg2E,
    output idPkg::regIdx_t   reg1Idx,
    output idPkg::regIdx_t   reg2Idx,
    output logic             idStall,
    output idPkg::addr_t     idExPc,
    output logic             idExRdE,
    output idPkg::regIdx_t   idExRdIdx,
    output idPkg::instIdx_t  idExInstIdx,
    output logic             idExValid,
    output idPkg::data_t     idExRs1Data,
    output idPkg::data_t     idExRs2Data,
    output idPkg::data_t     idExImm
);
    import idPkg::*;

    logic     rdE;
    regIdx_t  rdIdx;
    instIdx_t instIdx;
    logic     instValid;
    data_t    imm;
    data_t    rs1Data;
    data_t    rs2Data;
    logic     stall1;
    logic     stall2;

    instDecoder u_instDecoder (
        .inst(inst), .reg1E(reg1E), .reg2E(reg2E), .reg1Idx(reg1Idx), .reg2Idx(reg2Idx),
        .rdE(rdE), .rdIdx(rdIdx), .instIdx(instIdx), .instValid(instValid)
    );

    immGen u_immGen (.inst(inst), .imm(imm));

    // Hazard check looks at the instruction now sitting in the ID/EX register
    operandSelect u_rs1Select (
        .readE(reg1E), .readIdx(reg1Idx), .regData(reg1Data),
        .exFwdE(exFwdE), .exFwdIdx(exFwdIdx), .exFwdData(exFwdData),
        .memFwdE(memFwdE), .memFwdIdx(memFwdIdx), .memFwdData(memFwdData),
        .exInstIdx(idExInstIdx), .exRdIdx(idExRdIdx), .operand(rs1Data), .stall(stall1)
    );

    operandSelect u_rs2Select (
        .readE(reg2E), .readIdx(reg2Idx), .regData(reg2Data),
        .exFwdE(exFwdE), .exFwdIdx(exFwdIdx), .exFwdData(exFwdData),
        .memFwdE(memFwdE), .memFwdIdx(memFwdIdx), .memFwdData(memFwdData),
        .exInstIdx(idExInstIdx), .exRdIdx(idExRdIdx), .operand(rs2Data), .stall(stall2)
    );

    assign idStall = stall1 | stall2;

    idExReg u_idExReg (
        .clk(clk), .arstN(arstN), .stall(idStall), .pc(pc),
        .rdE(rdE), .rdIdx(rdIdx), .instIdx(instIdx), .instValid(instValid),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm),
        .exPc(idExPc), .exRdE(idExRdE), .exRdIdx(idExRdIdx), .exInstIdx(idExInstIdx),
        .exValid(idExValid), .exRs1Data(idExRs1Data), .exRs2Data(idExRs2Data), .exImm(idExImm)
    );

endmodule : idStage

//--- hw/immGen.sv
`timescale 1ns/1ps

module immGen (
    input  idPkg::inst_t  inst,
    output idPkg::data_t  imm
);
    import idPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    data_t      immI;
    data_t      immS;
    data_t      immB;
    data_t      immU;
    data_t      immJ;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {inst[31:12], 12'b0};
    assign immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (opcode)
            opLui, opAuipc: imm = immU;
            opJal:          imm = immJ;
            opJalr, opLoad: imm = immI;
            opBranch:       imm = immB;
            opStore:        imm = immS;
            opRegImm: begin
                if (funct3 == f3Sll || funct3 == f3SrlSra) begin
                    imm = {27'b0, inst[24:20]}; // Shift amount only
                end else begin
                    imm = immI;
                end
            end
            default:        imm = '0; // Register-register has no immediate
        endcase
    end

endmodule : immGen

//--- hw/instDecoder.sv
`timescale 1ns/1ps

module instDecoder (
    input  idPkg::inst_t     inst,
    output logic             reg1E,
    output logic             reg2E,
    output idPkg::regIdx_t   reg1Idx,
    output idPkg::regIdx_t   reg2Idx,
    output logic             rdE,
    output idPkg::regIdx_t   rdIdx,
    output idPkg::instIdx_t  instIdx,
    output logic             instValid
);
    import idPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       useRs1;
    logic       useRs2;
    logic       useRd;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7b5 = inst[30]; // Selects SUB and SRA variants

    always_comb begin
        instIdx = idNop;
        useRs1  = 1'b0;
        useRs2  = 1'b0;
        useRd   = 1'b0;
        case (opcode)
            opLui: begin
                instIdx = idLui;
                useRd   = 1'b1;
            end
            opAuipc: begin
                instIdx = idAuipc;
                useRd   = 1'b1;
            end
            opJal: begin
                instIdx = idJal;
                useRd   = 1'b1;
            end
            opJalr: begin
                if (funct3 == 3'b000) begin
                    instIdx = idJalr;
                end
                useRs1 = 1'b1;
                useRd  = 1'b1;
            end
            opBranch: begin
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                case (funct3)
                    3'b000:  instIdx = idBeq;
                    3'b001:  instIdx = idBne;
                    3'b100:  instIdx = idBlt;
                    3'b101:  instIdx = idBge;
                    3'b110:  instIdx = idBltu;
                    3'b111:  instIdx = idBgeu;
                    default: instIdx = idNop;
                endcase
            end
            opLoad: begin
                useRs1 = 1'b1;
                useRd  = 1'b1;
                case (funct3)
                    3'b000:  instIdx = idLb;
                    3'b001:  instIdx = idLh;
                    3'b010:  instIdx = idLw;
                    3'b100:  instIdx = idLbu;
                    3'b101:  instIdx = idLhu;
                    default: instIdx = idNop;
                endcase
            end
            opStore: begin
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                case (funct3)
                    3'b000:  instIdx = idSb;
                    3'b001:  instIdx = idSh;
                    3'b010:  instIdx = idSw;
                    default: instIdx = idNop;
                endcase
            end
            opRegImm: begin
                useRs1 = 1'b1;
                useRd  = 1'b1;
                case (funct3)
                    f3AddSub: instIdx = idAddi;
                    f3Sll:    instIdx = idSlli;
                    f3Slt:    instIdx = idSlti;
                    f3Sltu:   instIdx = idSltiu;
                    f3Xor:    instIdx = idXori;
                    f3SrlSra: instIdx = funct7b5 ? idSrai : idSrli;
                    f3Or:     instIdx = idOri;
                    f3And:    instIdx = idAndi;
                    default:  instIdx = idNop;
                endcase
            end
            opRegReg: begin
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                useRd  = 1'b1;
                case (funct3)
                    f3AddSub: instIdx = funct7b5 ? idSub : idAdd;
                    f3Sll:    instIdx = idSll;
                    f3Slt:    instIdx = idSlt;
                    f3Sltu:   instIdx = idSltu;
                    f3Xor:    instIdx = idXor;
                    f3SrlSra: instIdx = funct7b5 ? idSra : idSrl;
                    f3Or:     instIdx = idOr;
                    f3And:    instIdx = idAnd;
                    default:  instIdx = idNop;
                endcase
            end
            default: instIdx = idNop; // Unknown opcode
        endcase
    end

    // An undecoded word leaves every enable and index at zero
    assign instValid = (instIdx != idNop);
    assign reg1E     = instValid & useRs1;
    assign reg2E     = instValid & useRs2;
    assign rdE       = instValid & useRd;
    assign reg1Idx   = reg1E ? inst[19:15] : '0;
    assign reg2Idx   = reg2E ? inst[24:20] : '0;
    assign rdIdx     = rdE ? inst[11:7] : '0;

endmodule : instDecoder

//--- hw/operandSelect.sv
`timescale 1ns/1ps

module operandSelect (
    input  logic             readE,
    input  idPkg::regIdx_t   readIdx,
    input  idPkg::data_t     regData,
    input  logic             exFwdE,
    input  idPkg::regIdx_t   exFwdIdx,
    input  idPkg::data_t     exFwdData,
    input  logic             memFwdE,
    input  idPkg::regIdx_t   memFwdIdx,
    input  idPkg::data_t     memFwdData,
    input  idPkg::instIdx_t  exInstIdx,
    input  idPkg::regIdx_t   exRdIdx,
    output idPkg::data_t     operand,
    output logic             stall
);
    import idPkg::*;

    logic loadHit;
    logic exHit;
    logic memHit;

    // Load result is not ready until MEM, so the reader waits a cycle
    assign loadHit = isLoad(exInstIdx) && (exRdIdx == readIdx);
    assign exHit   = exFwdE && (exFwdIdx == readIdx);
    assign memHit  = memFwdE && (memFwdIdx == readIdx);

    always_comb begin
        stall   = 1'b0;
        operand = regData;
        if (!readE) begin
            operand = '0;
        end else if (readIdx == '0) begin
            operand = regData; // x0 is never forwarded
        end else if (loadHit) begin
            stall   = 1'b1;
            operand = '0;
        end else if (exHit) begin
            operand = exFwdData;
        end else if (memHit) begin
            operand = memFwdData;
        end
    end

endmodule : operandSelect
